// File: filelist.f
+incdir+source
source/ob_count_pkg.sv
source/ob_count_ctrl_if.sv
source/ob_count_sequencer.sv
source/ob_lane_group.sv
source/ob_count_accum.sv
source/ob_table_count.sv
test/tb_clock_gen.sv
test/ob_table_count_tb.sv

// File: test/ob_table_count_tb.sv
// Testbench for the ask-side order-book quantity counter, runs a stimulus table through the DUT
`timescale 1ns/10ps
`default_nettype none

`include "ob_count_consts.svh"

module ob_table_count_tb;

  localparam int NUM_ROWS = 16;
  localparam int BUSY_CYCLES = 5;
  localparam int DRIVE_DELAY = 2;
  localparam int CLK_PERIOD = 20;
  // Budget per row plus reset and margin
  localparam int TIMEOUT_CYCLES = NUM_ROWS * 20 + 50;

  // Valid flag patterns for the table
  localparam logic [1:0] FILL_ALL  = 2'd0;
  localparam logic [1:0] FILL_ALT  = 2'd1;
  localparam logic [1:0] FILL_NONE = 2'd2;

  // One stimulus row
  // total is only used for fixed rows, random rows use the reference sum
  typedef struct packed {
    logic [1:0]                    fill;
    logic                          rnd;
    logic                          pulse;
    ob_count_pkg::price_t          price;
    ob_count_pkg::quantity_t       target;
    ob_count_pkg::accum_quantity_t total;
  } stim_row_t;

  logic                                           clk;
  logic                                           reset;
  logic                                           cmd_vld;
  ob_count_pkg::price_t                           cmd_price;
  ob_count_pkg::quantity_t                        cmd_quantity;
  logic [`OB_TBL_ENTRIES-1:0]                     tbl_vld;
  ob_count_pkg::price_t [`OB_TBL_ENTRIES-1:0]     tbl_price;
  ob_count_pkg::quantity_t [`OB_TBL_ENTRIES-1:0]  tbl_quantity;
  logic                                           busy;
  ob_count_pkg::accum_quantity_t                  rsp_quantity;
  logic                                           rsp_attained;

  stim_row_t    rows [NUM_ROWS];
  int           errors;
  int unsigned  seed_ret;

  tb_clock_gen clock_gen_i (
    .clk   (clk),
    .reset (reset)
  );

  ob_table_count #(
    .is_ask (1'b1)
  ) ob_table_count_i (
    .clk          (clk),
    .reset        (reset),
    .cmd_vld      (cmd_vld),
    .cmd_price    (cmd_price),
    .cmd_quantity (cmd_quantity),
    .tbl_vld      (tbl_vld),
    .tbl_price    (tbl_price),
    .tbl_quantity (tbl_quantity),
    .busy         (busy),
    .rsp_quantity (rsp_quantity),
    .rsp_attained (rsp_attained)
  );

  // Four-state compare so that an unknown output is reported
  task automatic check_value(
    input string       what,
    input logic [31:0] actual,
    input logic [31:0] expected
  );
    if (actual !== expected) begin
      errors++;
      $display("ERROR at %0t ns: %s is %0d, expected %0d", $time, what, actual, expected);
    end
  endtask

  task automatic set_row(
    input int         idx,
    input logic [1:0] fill,
    input logic       rnd,
    input logic       pulse,
    input int         price,
    input int         target,
    input int         total
  );
    rows[idx].fill   = fill;
    rows[idx].rnd    = rnd;
    rows[idx].pulse  = pulse;
    rows[idx].price  = price;
    rows[idx].target = target;
    rows[idx].total  = total;
  endtask

  // Fixed table: price 100 + 10*i, quantity 20 + 3*i
  // Full sum 680, even entries only 328
  task automatic load_rows();
    // Targets just below, at and just above the full sum, second row carries a stray pulse
    set_row(0, FILL_ALL, 1'b0, 1'b0, 1000, 679, 680);
    set_row(1, FILL_ALL, 1'b0, 1'b0, 1000, 680, 680);
    set_row(2, FILL_ALL, 1'b0, 1'b1, 1000, 681, 680);
    // Equal price counts, higher prices drop out
    set_row(3, FILL_ALL, 1'b0, 1'b0, 150, 100, 165);
    set_row(4, FILL_ALL, 1'b0, 1'b0, 149, 130, 130);
    set_row(5, FILL_ALL, 1'b0, 1'b0, 99, 0, 0);
    // Crosses into the second round
    set_row(6, FILL_ALL, 1'b0, 1'b0, 160, 204, 203);
    // Odd entries invalid, entry 1 at equal price still excluded
    set_row(7, FILL_ALT, 1'b0, 1'b0, 1000, 400, 328);
    set_row(8, FILL_ALT, 1'b0, 1'b0, 110, 20, 20);
    set_row(9, FILL_ALT, 1'b0, 1'b0, 250, 327, 328);
    set_row(10, FILL_NONE, 1'b0, 1'b0, 1000, 1, 0);
    set_row(11, FILL_NONE, 1'b0, 1'b1, 250, 0, 0);
    // Random prices and quantities
    set_row(12, FILL_ALL, 1'b1, 1'b0, 500, 600, 0);
    set_row(13, FILL_ALL, 1'b1, 1'b1, 700, 1023, 0);
    set_row(14, FILL_ALT, 1'b1, 1'b0, 300, 200, 0);
    set_row(15, FILL_ALL, 1'b1, 1'b0, 999, 1000, 0);
  endtask

  task automatic fill_table(input logic [1:0] fill, input logic rnd);
    for (int e = 0; e < `OB_TBL_ENTRIES; e++) begin
      case (fill)
        FILL_ALL: tbl_vld[e] = 1'b1;
        FILL_ALT: tbl_vld[e] = (e % 2 == 0);
        default:  tbl_vld[e] = 1'b0;
      endcase
      if (rnd) begin
        tbl_price[e]    = $urandom % 1000;
        tbl_quantity[e] = $urandom % 1024;
      end else begin
        tbl_price[e]    = 100 + 10 * e;
        tbl_quantity[e] = 20 + 3 * e;
      end
    end
  endtask

  // Ask side reference: valid levels priced at or below the search price
  function automatic int ref_total(input ob_count_pkg::price_t price);
    int sum;
    sum = 0;
    for (int e = 0; e < `OB_TBL_ENTRIES; e++) begin
      if (tbl_vld[e] && (price >= tbl_price[e])) begin
        sum += tbl_quantity[e];
      end
    end
    return sum;
  endfunction

  // Issue one command and count the busy cycles until the DUT is idle again
  task automatic run_command(
    input  ob_count_pkg::price_t     price,
    input  ob_count_pkg::quantity_t  target,
    input  logic                     pulse,
    output int                       busy_cnt
  );
    cmd_price    = price;
    cmd_quantity = target;
    cmd_vld      = 1'b1;
    @(posedge clk);
    #DRIVE_DELAY;
    cmd_vld  = 1'b0;
    busy_cnt = 0;
    // Bounded well past the expected length
    while (busy && busy_cnt < 4 * BUSY_CYCLES) begin
      busy_cnt++;
      if (pulse && busy_cnt == 2) begin
        // Competing command mid sweep, must be dropped
        cmd_vld      = 1'b1;
        cmd_price    = ~price;
        cmd_quantity = ~target;
      end else begin
        cmd_vld = 1'b0;
      end
      @(posedge clk);
      #DRIVE_DELAY;
    end
  endtask

  initial begin
    int   busy_cnt;
    int   exp_total;
    logic exp_att;
    seed_ret     = $urandom(32'hf0cd_9f29);
    errors       = 0;
    cmd_vld      = 1'b0;
    cmd_price    = '0;
    cmd_quantity = '0;
    tbl_vld      = '0;
    tbl_price    = '0;
    tbl_quantity = '0;
    load_rows();

    @(negedge reset);
    // Idle, cleared accumulator and zero target
    check_value("busy after reset", busy, 0);
    check_value("quantity after reset", rsp_quantity, 0);
    check_value("attained after reset", rsp_attained, 1);

    for (int i = 0; i < NUM_ROWS; i++) begin
      fill_table(rows[i].fill, rows[i].rnd);
      exp_total = rows[i].rnd ? ref_total(rows[i].price) : int'(rows[i].total);
      exp_att   = (exp_total >= rows[i].target);
      run_command(rows[i].price, rows[i].target, rows[i].pulse, busy_cnt);
      check_value($sformatf("row %0d busy cycles", i), busy_cnt, BUSY_CYCLES);
      check_value($sformatf("row %0d quantity", i), rsp_quantity, exp_total);
      check_value($sformatf("row %0d attained", i), rsp_attained, exp_att);
      // Result holds while idle
      @(posedge clk);
      #DRIVE_DELAY;
      check_value($sformatf("row %0d held quantity", i), rsp_quantity, exp_total);
      check_value($sformatf("row %0d held attained", i), rsp_attained, exp_att);
    end

    $display("Errors: %0d", errors);
    if (errors == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

  // Watchdog
  initial begin
    #(TIMEOUT_CYCLES * CLK_PERIOD);
    $display("Timeout: the run did not finish within %0d clock cycles", TIMEOUT_CYCLES);
    $display("STATUS: FAIL");
    $finish;
  end

endmodule

`default_nettype wire

// File: test/tb_clock_gen.sv
// Testbench clock source, 20 ns period, with a synchronous reset held for the first 10 cycles
`timescale 1ns/10ps
`default_nettype none

module tb_clock_gen (
  output logic clk,
  output logic reset
);

  // Half of the 20 ns period
  localparam int HALF_PERIOD = 10;
  localparam int RESET_CYCLES = 10;

  initial begin
    clk = 1'b0;
    forever begin
      #(HALF_PERIOD) clk = ~clk;
    end
  end

  // Released shortly after a rising edge, like all other stimulus
  initial begin
    reset = 1'b1;
    repeat (RESET_CYCLES) @(posedge clk);
    #2 reset = 1'b0;
  end

endmodule

`default_nettype wire

// File: source/ob_table_count.sv
// Top level of the order-book quantity counter with plain command and table ports
`timescale 1ns/10ps
`default_nettype none

`include "ob_count_consts.svh"

module ob_table_count #(
  // 1 for the ask side, 0 for the bid side
  parameter bit is_ask = 1'b1
) (
  input  logic                                           clk,
  input  logic                                           reset,
  input  logic                                           cmd_vld,
  input  ob_count_pkg::price_t                           cmd_price,
  input  ob_count_pkg::quantity_t                        cmd_quantity,
  input  logic [`OB_TBL_ENTRIES-1:0]                     tbl_vld,
  input  ob_count_pkg::price_t [`OB_TBL_ENTRIES-1:0]     tbl_price,
  input  ob_count_pkg::quantity_t [`OB_TBL_ENTRIES-1:0]  tbl_quantity,
  output logic                                           busy,
  output ob_count_pkg::accum_quantity_t                  rsp_quantity,
  output logic                                           rsp_attained
);

  ob_count_pkg::tbl_entry_t [`OB_TBL_ENTRIES-1:0]  tbl;
  ob_count_pkg::accum_quantity_t                   sum_a;
  ob_count_pkg::accum_quantity_t                   carry_a;
  ob_count_pkg::accum_quantity_t                   sum_b;
  ob_count_pkg::accum_quantity_t                   carry_b;

  ob_count_ctrl_if ctrl_if ();

  // Table fields gathered into entries
  for (genvar e = 0; e < `OB_TBL_ENTRIES; e++) begin : g_pack
    assign tbl[e] = '{vld: tbl_vld[e], price: tbl_price[e], quantity: tbl_quantity[e]};
  end

  ob_count_sequencer sequencer_i (
    .clk          (clk),
    .reset        (reset),
    .cmd_vld      (cmd_vld),
    .cmd_price    (cmd_price),
    .cmd_quantity (cmd_quantity),
    .busy         (busy),
    .ctrl         (ctrl_if.sequencer)
  );

  // Lanes 0 to 2 of each round
  ob_lane_group #(
    .is_ask     (is_ask),
    .group_base (0)
  ) lane_group_a_i (
    .clk        (clk),
    .reset      (reset),
    .tbl        (tbl),
    .ctrl       (ctrl_if.lane),
    .part_sum   (sum_a),
    .part_carry (carry_a)
  );

  // Lanes 3 to 5 of each round
  ob_lane_group #(
    .is_ask     (is_ask),
    .group_base (`OB_GROUP_LANES)
  ) lane_group_b_i (
    .clk        (clk),
    .reset      (reset),
    .tbl        (tbl),
    .ctrl       (ctrl_if.lane),
    .part_sum   (sum_b),
    .part_carry (carry_b)
  );

  ob_count_accum accum_i (
    .clk          (clk),
    .reset        (reset),
    .ctrl         (ctrl_if.accum),
    .sum_a        (sum_a),
    .carry_a      (carry_a),
    .sum_b        (sum_b),
    .carry_b      (carry_b),
    .rsp_quantity (rsp_quantity),
    .rsp_attained (rsp_attained)
  );

endmodule

`default_nettype wire

// File: source/ob_count_accum.sv
// Carry-save accumulator of both lane groups with final add and attained compare
`timescale 1ns/10ps
`default_nettype none

module ob_count_accum (
  input  logic                           clk,
  input  logic                           reset,
  ob_count_ctrl_if.accum                 ctrl,
  input  ob_count_pkg::accum_quantity_t  sum_a,
  input  ob_count_pkg::accum_quantity_t  carry_a,
  input  ob_count_pkg::accum_quantity_t  sum_b,
  input  ob_count_pkg::accum_quantity_t  carry_b,
  output ob_count_pkg::accum_quantity_t  rsp_quantity,
  output logic                           rsp_attained
);

  // Running pair in carry-save form
  ob_count_pkg::accum_quantity_t  acc_s;
  ob_count_pkg::accum_quantity_t  acc_c;
  // Intermediate pairs of the 6:2 chain
  ob_count_pkg::accum_quantity_t  s1;
  ob_count_pkg::accum_quantity_t  c1;
  ob_count_pkg::accum_quantity_t  s2;
  ob_count_pkg::accum_quantity_t  c2;
  ob_count_pkg::accum_quantity_t  s3;
  ob_count_pkg::accum_quantity_t  c3;
  ob_count_pkg::accum_quantity_t  new_s;
  ob_count_pkg::accum_quantity_t  new_c;

  function automatic ob_count_pkg::accum_quantity_t csa_sum(
    input ob_count_pkg::accum_quantity_t x,
    input ob_count_pkg::accum_quantity_t y,
    input ob_count_pkg::accum_quantity_t z
  );
    return x ^ y ^ z;
  endfunction

  // Carry moves one bit up, the top carry drops since the total fits
  function automatic ob_count_pkg::accum_quantity_t csa_carry(
    input ob_count_pkg::accum_quantity_t x,
    input ob_count_pkg::accum_quantity_t y,
    input ob_count_pkg::accum_quantity_t z
  );
    return ((x & y) | (x & z) | (y & z)) << 1;
  endfunction

  // Six terms down to four
  assign s1 = csa_sum(sum_a, carry_a, sum_b);
  assign c1 = csa_carry(sum_a, carry_a, sum_b);
  assign s2 = csa_sum(carry_b, acc_s, acc_c);
  assign c2 = csa_carry(carry_b, acc_s, acc_c);

  // Four to three
  assign s3 = csa_sum(s1, c1, s2);
  assign c3 = csa_carry(s1, c1, s2);

  // Three to the new pair
  assign new_s = csa_sum(c2, s3, c3);
  assign new_c = csa_carry(c2, s3, c3);

  always_ff @(posedge clk) begin
    if (reset || ctrl.acc_init) begin
      acc_s <= '0;
      acc_c <= '0;
    end else if (ctrl.acc_upt) begin
      acc_s <= new_s;
      acc_c <= new_c;
    end
  end

  // Single carry-propagate add
  assign rsp_quantity = acc_s + acc_c;

  assign rsp_attained =
    (rsp_quantity >= ob_count_pkg::accum_quantity_t'(ctrl.target_quantity));

  // Clear and accumulate come from disjoint sequencer states
  a_init_upt_excl: assert property (
    @(posedge clk) disable iff (reset)
    !(ctrl.acc_init && ctrl.acc_upt)
  );

endmodule

`default_nettype wire

// File: source/ob_lane_group.sv
// Three-lane price qualification and capture with 3:2 reduction for one half of the table
`timescale 1ns/10ps
`default_nettype none

`include "ob_count_consts.svh"

module ob_lane_group #(
  // Ask side counts entries priced at or below the search price
  parameter bit is_ask     = 1'b1,
  // Table lane of the first lane in this group
  parameter int group_base = 0
) (
  input  logic                                            clk,
  input  logic                                            reset,
  input  ob_count_pkg::tbl_entry_t [`OB_TBL_ENTRIES-1:0]  tbl,
  ob_count_ctrl_if.lane                                   ctrl,
  output ob_count_pkg::accum_quantity_t                   part_sum,
  output ob_count_pkg::accum_quantity_t                   part_carry
);

  // Table entries seen by each lane in each round
  ob_count_pkg::tbl_entry_t                              slot [`OB_ROUNDS][`OB_GROUP_LANES];
  ob_count_pkg::quantity_t [`OB_GROUP_LANES-1:0]         lane_w;
  ob_count_pkg::quantity_t [`OB_GROUP_LANES-1:0]         lane_r;
  ob_count_pkg::accum_quantity_t                         term_a;
  ob_count_pkg::accum_quantity_t                         term_b;
  ob_count_pkg::accum_quantity_t                         term_c;

  // Price rule for this book side
  function automatic logic price_ok(
    input ob_count_pkg::price_t cmd_px,
    input ob_count_pkg::price_t ent_px
  );
    if (is_ask) begin
      // Buyer pays at least the asking price
      return (cmd_px >= ent_px);
    end else begin
      // Seller accepts at most the bid price
      return (cmd_px <= ent_px);
    end
  endfunction

  // Lane l in round r reads entry r*6 + group_base + l
  // Slots past the table end read as empty
  for (genvar r = 0; r < `OB_ROUNDS; r++) begin : g_round
    for (genvar l = 0; l < `OB_GROUP_LANES; l++) begin : g_lane
      localparam int idx = r * `OB_LANES + group_base + l;
      if (idx < `OB_TBL_ENTRIES) begin : g_entry
        assign slot[r][l] = tbl[idx];
      end else begin : g_pad
        assign slot[r][l] = '0;
      end
    end
  end

  // One-hot round mux, gated by valid and price
  always_comb begin
    for (int l = 0; l < `OB_GROUP_LANES; l++) begin
      lane_w[l] = '0;
      for (int r = 0; r < `OB_ROUNDS; r++) begin
        if (ctrl.round_sel[r] && slot[r][l].vld &&
            price_ok(ctrl.search_price, slot[r][l].price)) begin
          lane_w[l] = lane_w[l] | slot[r][l].quantity;
        end
      end
    end
  end

  // Capture the selected round
  always_ff @(posedge clk) begin
    if (reset) begin
      lane_r <= '0;
    end else if (ctrl.capture) begin
      lane_r <= lane_w;
    end
  end

  // Widen to accumulator width before reducing
  assign term_a = ob_count_pkg::accum_quantity_t'(lane_r[0]);
  assign term_b = ob_count_pkg::accum_quantity_t'(lane_r[1]);
  assign term_c = ob_count_pkg::accum_quantity_t'(lane_r[2]);

  // 3:2 step, bitwise sum and shifted majority
  assign part_sum   = term_a ^ term_b ^ term_c;
  assign part_carry = ((term_a & term_b) | (term_a & term_c) | (term_b & term_c)) << 1;

  // Capture must see a single round
  a_capture_onehot: assert property (
    @(posedge clk) disable iff (reset)
    ctrl.capture |-> $onehot(ctrl.round_sel)
  );

endmodule

`default_nettype wire

// File: source/ob_count_sequencer.sv
// Command acceptance and round sequencing FSM driving the lane groups and accumulator
`timescale 1ns/10ps
`default_nettype none

`include "ob_count_consts.svh"

module ob_count_sequencer (
  input  logic                     clk,
  input  logic                     reset,
  input  logic                     cmd_vld,
  input  ob_count_pkg::price_t     cmd_price,
  input  ob_count_pkg::quantity_t  cmd_quantity,
  output logic                     busy,
  ob_count_ctrl_if.sequencer       ctrl
);

  ob_count_pkg::seq_state_t  state;
  ob_count_pkg::seq_state_t  state_next;
  ob_count_pkg::round_sel_t  round_sel_r;
  ob_count_pkg::price_t      search_price_r;
  ob_count_pkg::quantity_t   target_quantity_r;
  logic                      accept;
  logic                      last_round;

  // Any state other than IDLE holds off new commands
  assign busy = (state != ob_count_pkg::IDLE);

  // Commands seen while busy are dropped
  assign accept = cmd_vld && (state == ob_count_pkg::IDLE);

  // Final round of the sweep is selected
  assign last_round = round_sel_r[`OB_ROUNDS-1];

  // Next state
  always_comb begin
    state_next = state;
    case (state)
      ob_count_pkg::IDLE: begin
        if (cmd_vld) begin
          state_next = ob_count_pkg::ACCUM;
        end
      end
      ob_count_pkg::ACCUM: begin
        // One cycle per round, leave after the last one
        if (last_round) begin
          state_next = ob_count_pkg::WAIT0;
        end
      end
      ob_count_pkg::WAIT0: begin
        state_next = ob_count_pkg::WAIT1;
      end
      ob_count_pkg::WAIT1: begin
        state_next = ob_count_pkg::IDLE;
      end
      default: begin
        state_next = ob_count_pkg::IDLE;
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= ob_count_pkg::IDLE;
    end else begin
      state <= state_next;
    end
  end

  // Round select, restarts at the first round on acceptance
  always_ff @(posedge clk) begin
    if (reset) begin
      round_sel_r <= '0;
    end else if (accept) begin
      round_sel_r <= ob_count_pkg::round_sel_t'(1);
    end else if (state == ob_count_pkg::ACCUM) begin
      round_sel_r <= round_sel_r << 1;
    end
  end

  // Search context
  // Target clears to zero so the attained flag starts high
  always_ff @(posedge clk) begin
    if (reset) begin
      search_price_r    <= '0;
      target_quantity_r <= '0;
    end else if (accept) begin
      search_price_r    <= cmd_price;
      target_quantity_r <= cmd_quantity;
    end
  end

  assign ctrl.round_sel       = round_sel_r;
  assign ctrl.search_price    = search_price_r;
  assign ctrl.target_quantity = target_quantity_r;

  // Lanes load the selected round in every ACCUM cycle
  assign ctrl.capture = (state == ob_count_pkg::ACCUM);

  // Accumulator cleared in the accept cycle
  assign ctrl.acc_init = accept;

  // Lane registers hold data from the second ACCUM cycle through WAIT0
  assign ctrl.acc_upt = ((state == ob_count_pkg::ACCUM) && !round_sel_r[0]) ||
                        (state == ob_count_pkg::WAIT0);

  // Exactly one round selected while sweeping
  a_round_onehot: assert property (
    @(posedge clk) disable iff (reset)
    (state == ob_count_pkg::ACCUM) |-> $onehot(round_sel_r)
  );

  // The sweep lasts one cycle per round and then drains
  a_accum_length: assert property (
    @(posedge clk) disable iff (reset)
    (state != ob_count_pkg::ACCUM) ##1 (state == ob_count_pkg::ACCUM) |->
      (state == ob_count_pkg::ACCUM) [*`OB_ROUNDS] ##1 (state == ob_count_pkg::WAIT0)
  );

endmodule

`default_nettype wire

// File: source/ob_count_ctrl_if.sv
// Round control from the sequencer to the lane groups and the accumulator
`timescale 1ns/10ps
`default_nettype none

interface ob_count_ctrl_if ();

  // Current round, one-hot
  ob_count_pkg::round_sel_t      round_sel;
  // Search context held for the whole command
  ob_count_pkg::price_t          search_price;
  ob_count_pkg::quantity_t       target_quantity;
  // Lane registers load the selected round
  logic                          capture;
  // Accumulator clear and accumulate strobes
  logic                          acc_init;
  logic                          acc_upt;

  modport sequencer (
    output round_sel,
    output search_price,
    output target_quantity,
    output capture,
    output acc_init,
    output acc_upt
  );

  modport lane (
    input round_sel,
    input search_price,
    input capture
  );

  modport accum (
    input target_quantity,
    input acc_init,
    input acc_upt
  );

endinterface

`default_nettype wire

// File: source/ob_count_pkg.sv
// Shared types of the order-book quantity counter, referenced by scoped names in the RTL
`default_nettype none

`include "ob_count_consts.svh"

package ob_count_pkg;

  // Price of a table entry or of a search command
  typedef logic [`OB_PRICE_W-1:0] price_t;

  // Quantity held at one price level
  typedef logic [`OB_QTY_W-1:0] quantity_t;

  // Quantity after summing over levels
  typedef logic [`OB_ACC_W-1:0] accum_quantity_t;

  // One price level of the book
  typedef struct packed {
    logic      vld;
    price_t    price;
    quantity_t quantity;
  } tbl_entry_t;

  // Sequencer states
  // IDLE waits for a command, ACCUM sweeps the rounds,
  // WAIT0 drains the last round, WAIT1 lets the final add settle
  typedef enum logic [1:0] {
    IDLE  = 2'd0,
    ACCUM = 2'd1,
    WAIT0 = 2'd2,
    WAIT1 = 2'd3
  } seq_state_t;

  // One-hot select of the current round
  typedef logic [`OB_ROUNDS-1:0] round_sel_t;

endpackage

`default_nettype wire

// File: source/ob_count_consts.svh
// Size and width defines for the order-book quantity counter, included by the package and RTL
`ifndef OB_COUNT_CONSTS_SVH
`define OB_COUNT_CONSTS_SVH

// Price levels held in the book table
`define OB_TBL_ENTRIES 16

// Lanes swept per round over both lane groups
`define OB_LANES 6

// Lanes handled by one lane group
`define OB_GROUP_LANES 3

// Rounds needed to cover the table, entries over lanes rounded up
`define OB_ROUNDS ((`OB_TBL_ENTRIES + `OB_LANES - 1) / `OB_LANES)

// Price field width
`define OB_PRICE_W 16

// Quantity of a single table entry
`define OB_QTY_W 10

// Summed quantity, wide enough for all entries at full quantity
`define OB_ACC_W 16

`endif
